// File: common/l2_cache_pkg.sv
// fixed 28-bit word address, 128-bit words, 4 words per line, 4 ways; index width is a module parameter
`default_nettype none

package l2_cache_pkg;

    // word address width
    parameter int ADDR_BITS      = 28;
    // associativity
    parameter int WAYS           = 4;
    parameter int WORDS_PER_LINE = 4;

    // word address, offset in the two low bits
    typedef logic [ADDR_BITS-1:0] addr_t;
    // address without word offset
    typedef logic [ADDR_BITS-3:0] line_addr_t;
    typedef logic [127:0]         word_t;
    // word n sits at bits 128n upward
    typedef logic [511:0]         line_t;
    typedef logic [1:0]           way_t;
    typedef logic [1:0]           word_sel_t;
    typedef logic [3:0]           word_mask_t;
    // bit 0 picks the pair, bit 1 ways 0/1, bit 2 ways 2/3
    typedef logic [2:0]           plru_t;

    // requester command, rw high for a write
    typedef struct packed {
        addr_t addr;
        logic  rw;
        word_t wdata;
    } l2_req_t;

    // memory command, one full line per transfer
    typedef struct packed {
        logic       rw;
        line_addr_t line_addr;
        line_t      wdata;
    } mem_req_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_RESPOND
    } l2_state_t;

endpackage

`default_nettype wire

// File: rtl/l2_req_arbiter.sv
// fixed priority to ic; requesters must hold req and cmd until their done is seen
`timescale 1ns/1ps
`default_nettype none

module l2_req_arbiter
    import l2_cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    ic_req,
    input  wire l2_req_t ic_cmd,
    input  wire logic    dc_req,
    input  wire l2_req_t dc_cmd,
    output logic         cmd_valid,
    output l2_req_t      cmd,
    input  wire logic    done,
    output logic         ic_done,
    output logic         dc_done
);

    // transaction in flight
    logic busy;
    // 1 when the dc port owns the cache
    logic owner_dc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            owner_dc <= 1'b0;
        end else if (!busy) begin
            if (ic_req || dc_req) begin
                busy     <= 1'b1;
                // ic first when both ask
                owner_dc <= !ic_req;
            end
        end else if (done) begin
            // free again after the response cycle
            busy <= 1'b0;
        end
    end

    assign cmd_valid = busy;

    // owner's cmd stays stable while it waits for done
    assign cmd = owner_dc ? dc_cmd : ic_cmd;

    // completion back to the owner only
    assign ic_done = done && !owner_dc;
    assign dc_done = done && owner_dc;

endmodule

`default_nettype wire

// File: rtl/l2_tag_store.sv
// combinational read, one-cycle write; valid, dirty and plru clear on reset, tags do not
`timescale 1ns/1ps
`default_nettype none

module l2_tag_store
    import l2_cache_pkg::*;
#(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 17
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [INDEX_BITS-1:0]   index,
    output logic [WAYS-1:0][TAG_BITS-1:0] tags,
    output word_mask_t                   valid,
    output word_mask_t                   dirty,
    output plru_t                        plru,
    input  wire logic                    tag_we,
    input  wire way_t                    wr_way,
    input  wire logic [TAG_BITS-1:0]     wr_tag,
    input  wire logic                    wr_dirty,
    input  wire logic                    plru_we,
    input  wire plru_t                   plru_wd
);

    localparam int SETS = 1 << INDEX_BITS;

    // tag array, all ways of a set in one entry
    logic [WAYS-1:0][TAG_BITS-1:0] tag_mem [SETS];

    // per-set status bits
    word_mask_t valid_q [SETS];
    word_mask_t dirty_q [SETS];
    plru_t      plru_q  [SETS];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[index][wr_way] <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            plru_q  <= '{default: '0};
        end else begin
            // a tag write always makes the way valid
            if (tag_we) begin
                valid_q[index][wr_way] <= 1'b1;
                dirty_q[index][wr_way] <= wr_dirty;
            end
            if (plru_we) begin
                plru_q[index] <= plru_wd;
            end
        end
    end

    // read side
    assign tags  = tag_mem[index];
    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign plru  = plru_q[index];

endmodule

`default_nettype wire

// File: rtl/l2_data_store.sv
// combinational read of all ways; write enable per word, one way per cycle; no reset on contents
`timescale 1ns/1ps
`default_nettype none

module l2_data_store
    import l2_cache_pkg::*;
#(
    parameter int INDEX_BITS = 9
) (
    input  wire logic                  clk,
    input  wire logic [INDEX_BITS-1:0] index,
    output line_t [WAYS-1:0]           lines,
    input  wire word_mask_t            we,
    input  wire way_t                  wr_way,
    input  wire line_t                 wdata
);

    localparam int SETS = 1 << INDEX_BITS;

    // line storage per set and way
    line_t mem_q [SETS][WAYS];

    always_ff @(posedge clk) begin
        // masked words only, rest of the line kept
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (we[w]) begin
                mem_q[index][wr_way][w*128 +: 128] <= wdata[w*128 +: 128];
            end
        end
    end

    // all four ways out for hit data and victim writeback
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lines[w] = mem_q[index][w];
        end
    end

endmodule

`default_nettype wire

// File: l2_ctrl/l2_way_select.sv
// purely combinational; assumes at most one way holds a given tag
`timescale 1ns/1ps
`default_nettype none

module l2_way_select
    import l2_cache_pkg::*;
#(
    parameter int TAG_BITS = 17
) (
    input  wire logic [TAG_BITS-1:0]            cmd_tag,
    input  wire logic [WAYS-1:0][TAG_BITS-1:0]  tags,
    input  wire word_mask_t                     valid,
    input  wire word_mask_t                     dirty,
    input  wire plru_t                          plru,
    output logic                                hit,
    output way_t                                hit_way,
    output way_t                                victim_way,
    output logic                                victim_dirty,
    output logic [TAG_BITS-1:0]                 victim_tag,
    output plru_t                               plru_next
);

    logic any_invalid;
    way_t first_invalid;
    way_t plru_way;
    way_t acc_way;

    // tag compare on valid ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        // walk downward so the lowest match wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (valid[w] && tags[w] == cmd_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way, if any
    always_comb begin
        any_invalid   = 1'b0;
        first_invalid = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                any_invalid   = 1'b1;
                first_invalid = way_t'(w);
            end
        end
    end

    // tree walk, bit 0 first
    assign plru_way = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};

    assign victim_way   = any_invalid ? first_invalid : plru_way;
    assign victim_dirty = valid[victim_way] && dirty[victim_way];
    assign victim_tag   = tags[victim_way];

    // way being touched by this access
    assign acc_way = hit ? hit_way : victim_way;

    // point the tree away from the touched way
    always_comb begin
        plru_next = plru;
        if (!acc_way[1]) begin
            plru_next[0] = 1'b1;
            plru_next[1] = !acc_way[0];
        end else begin
            plru_next[0] = 1'b0;
            plru_next[2] = !acc_way[0];
        end
    end

endmodule

`default_nettype wire

// File: l2_ctrl/l2_ctrl_fsm.sv
// cmd must stay stable from grant to done; mem_req and mem_cmd held until mem_done
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm
    import l2_cache_pkg::*;
#(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 17
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // granted command
    input  wire logic                  cmd_valid,
    input  wire l2_req_t               cmd,
    output logic                       done,
    output word_t                      rdata,
    // store control
    output logic [INDEX_BITS-1:0]      index,
    output logic                       tag_we,
    output way_t                       wr_way,
    output logic [TAG_BITS-1:0]        wr_tag,
    output logic                       wr_dirty,
    output word_mask_t                 data_we,
    output line_t                      data_wdata,
    output logic                       plru_we,
    output plru_t                      plru_wd,
    input  wire line_t [WAYS-1:0]      lines,
    // way selection
    input  wire logic                  hit,
    input  wire way_t                  hit_way,
    input  wire way_t                  victim_way,
    input  wire logic                  victim_dirty,
    input  wire logic [TAG_BITS-1:0]   victim_tag,
    input  wire plru_t                 plru_next,
    // memory
    output logic                       mem_req,
    output mem_req_t                   mem_cmd,
    input  wire logic                  mem_done,
    input  wire line_t                 mem_rdata
);

    l2_state_t state, state_next;

    // address fields of the current command
    logic [TAG_BITS-1:0] cmd_tag;
    word_sel_t           word_sel;

    // latched at lookup on a miss
    way_t                victim_q;
    logic [TAG_BITS-1:0] victim_tag_q;
    word_t               rdata_q;

    // fetched line with the write word merged in
    line_t               fill_line;

    assign cmd_tag  = cmd.addr[ADDR_BITS-1 -: TAG_BITS];
    assign index    = cmd.addr[INDEX_BITS+1:2];
    assign word_sel = cmd.addr[1:0];

    always_comb begin
        fill_line = mem_rdata;
        if (cmd.rw) begin
            fill_line[int'(word_sel)*128 +: 128] = cmd.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // next state and store writes
    always_comb begin
        state_next = state;
        tag_we     = 1'b0;
        wr_way     = hit_way;
        wr_tag     = cmd_tag;
        wr_dirty   = 1'b0;
        data_we    = '0;
        data_wdata = {WORDS_PER_LINE{cmd.wdata}};
        plru_we    = 1'b0;
        plru_wd    = plru_next;
        case (state)
            ST_IDLE: begin
                if (cmd_valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    plru_we    = 1'b1;
                    state_next = ST_RESPOND;
                    // write hit, one word and the dirty bit
                    if (cmd.rw) begin
                        tag_we   = 1'b1;
                        wr_dirty = 1'b1;
                        data_we  = word_mask_t'(1) << word_sel;
                    end
                end else if (victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_done) begin
                    state_next = ST_REFILL;
                end
            end
            ST_REFILL: begin
                wr_way     = victim_q;
                data_wdata = fill_line;
                if (mem_done) begin
                    // whole line in, tag set, dirty only for a write
                    tag_we     = 1'b1;
                    wr_dirty   = cmd.rw;
                    data_we    = '1;
                    plru_we    = 1'b1;
                    state_next = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            victim_q     <= victim_way;
            victim_tag_q <= victim_tag;
            if (hit) begin
                rdata_q <= lines[hit_way][int'(word_sel)*128 +: 128];
            end
        end else if (state == ST_REFILL && mem_done) begin
            // requested word straight from memory
            rdata_q <= mem_rdata[int'(word_sel)*128 +: 128];
        end
    end

    assign done  = (state == ST_RESPOND);
    assign rdata = rdata_q;

    // memory command follows the state
    assign mem_req           = (state == ST_WRITEBACK) || (state == ST_REFILL);
    assign mem_cmd.rw        = (state == ST_WRITEBACK);
    assign mem_cmd.line_addr = (state == ST_WRITEBACK) ? {victim_tag_q, index}
                                                       : cmd.addr[ADDR_BITS-1:2];
    // victim line for writeback
    assign mem_cmd.wdata     = lines[victim_q];

endmodule

`default_nettype wire

// File: rtl/l2_cache_top.sv
// one transaction in flight; ic wins over dc; memory must hold mem_rdata valid with mem_done
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top
    import l2_cache_pkg::*;
#(
    parameter int INDEX_BITS = 9
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    // instruction port
    input  wire logic     ic_req,
    input  wire l2_req_t  ic_cmd,
    output logic          ic_done,
    // data port
    input  wire logic     dc_req,
    input  wire l2_req_t  dc_cmd,
    output logic          dc_done,
    // shared read data
    output word_t         rdata,
    // memory side
    output logic          mem_req,
    output mem_req_t      mem_cmd,
    input  wire logic     mem_done,
    input  wire line_t    mem_rdata
);

    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - 2;

    // arbiter to controller
    logic                          cmd_valid;
    l2_req_t                       cmd;
    logic                          done;

    // store read side
    logic [INDEX_BITS-1:0]         index;
    logic [WAYS-1:0][TAG_BITS-1:0] tags;
    word_mask_t                    valid;
    word_mask_t                    dirty;
    plru_t                         plru;
    line_t [WAYS-1:0]              lines;

    // store write side
    logic                          tag_we;
    way_t                          wr_way;
    logic [TAG_BITS-1:0]           wr_tag;
    logic                          wr_dirty;
    logic                          plru_we;
    plru_t                         plru_wd;
    word_mask_t                    data_we;
    line_t                         data_wdata;

    // way selection results
    logic                          hit;
    way_t                          hit_way;
    way_t                          victim_way;
    logic                          victim_dirty;
    logic [TAG_BITS-1:0]           victim_tag;
    plru_t                         plru_next;

    l2_req_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .ic_req    (ic_req),
        .ic_cmd    (ic_cmd),
        .dc_req    (dc_req),
        .dc_cmd    (dc_cmd),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .ic_done   (ic_done),
        .dc_done   (dc_done)
    );

    l2_ctrl_fsm #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .done         (done),
        .rdata        (rdata),
        .index        (index),
        .tag_we       (tag_we),
        .wr_way       (wr_way),
        .wr_tag       (wr_tag),
        .wr_dirty     (wr_dirty),
        .data_we      (data_we),
        .data_wdata   (data_wdata),
        .plru_we      (plru_we),
        .plru_wd      (plru_wd),
        .lines        (lines),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .plru_next    (plru_next),
        .mem_req      (mem_req),
        .mem_cmd      (mem_cmd),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata)
    );

    // tag of the granted command compared against all ways
    l2_way_select #(
        .TAG_BITS (TAG_BITS)
    ) u_way_select (
        .cmd_tag      (cmd.addr[ADDR_BITS-1 -: TAG_BITS]),
        .tags         (tags),
        .valid        (valid),
        .dirty        (dirty),
        .plru         (plru),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .plru_next    (plru_next)
    );

    l2_tag_store #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_tag_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .tags     (tags),
        .valid    (valid),
        .dirty    (dirty),
        .plru     (plru),
        .tag_we   (tag_we),
        .wr_way   (wr_way),
        .wr_tag   (wr_tag),
        .wr_dirty (wr_dirty),
        .plru_we  (plru_we),
        .plru_wd  (plru_wd)
    );

    l2_data_store #(
        .INDEX_BITS (INDEX_BITS)
    ) u_data_store (
        .clk    (clk),
        .index  (index),
        .lines  (lines),
        .we     (data_we),
        .wr_way (wr_way),
        .wdata  (data_wdata)
    );

endmodule

`default_nettype wire

// File: bench/l2_cache_tb.sv
// INDEX_BITS fixed to 4 (16 sets); reads bench/l2_cache_patterns.txt, so run from the project root
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
    import l2_cache_pkg::*;
();

    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - 2;
    localparam int SETS       = 1 << INDEX_BITS;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     ic_req;
    l2_req_t  ic_cmd;
    logic     ic_done;
    logic     dc_req;
    l2_req_t  dc_cmd;
    logic     dc_done;
    word_t    rdata;
    logic     mem_req;
    mem_req_t mem_cmd;
    logic     mem_done;
    line_t    mem_rdata;

    // pattern table, one entry per file line
    logic [7:0] op_q [$];
    logic [7:0] port_q [$];
    addr_t      addr_q [$];
    word_t      wdata_q [$];

    logic started;
    int   limit;
    int   cycles;

    // memory model
    word_t       mem_words [addr_t];
    logic [31:0] rng;
    int          lat;
    mem_req_t    req_cmd;
    // every memory command, in order of arrival
    logic        log_rw [$];
    line_addr_t  log_addr [$];
    line_t       log_data [$];
    int          log_seen;

    // latest word values, plus tag and plru state per set
    word_t               ref_words [addr_t];
    logic [TAG_BITS-1:0] m_tag   [SETS][WAYS];
    logic                m_valid [SETS][WAYS];
    logic                m_dirty [SETS][WAYS];
    plru_t               m_plru  [SETS];

    l2_cache_top #(
        .INDEX_BITS (INDEX_BITS)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ic_req    (ic_req),
        .ic_cmd    (ic_cmd),
        .ic_done   (ic_done),
        .dc_req    (dc_req),
        .dc_cmd    (dc_cmd),
        .dc_done   (dc_done),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            $display("Error %s: got %0h, expected %0h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents out of reset: word address in every 32-bit lane
    function automatic word_t init_word(input addr_t a);
        return {4{{4'b0000, a}}};
    endfunction

    function automatic word_t ref_word(input addr_t a);
        if (ref_words.exists(a)) begin
            return ref_words[a];
        end
        return init_word(a);
    endfunction

    function automatic line_t ref_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*128 +: 128] = ref_word({la, word_sel_t'(w)});
        end
        return l;
    endfunction

    function automatic line_t mem_line(input line_addr_t la);
        line_t l;
        addr_t a;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            a = {la, word_sel_t'(w)};
            l[w*128 +: 128] = mem_words.exists(a) ? mem_words[a] : init_word(a);
        end
        return l;
    endfunction

    // bit 0 selects the pair, bit 1 or bit 2 the way inside it
    function automatic way_t plru_pick(input plru_t p);
        way_t w;
        if (p[0]) begin
            w = p[2] ? 2'd3 : 2'd2;
        end else begin
            w = p[1] ? 2'd1 : 2'd0;
        end
        return w;
    endfunction

    // point the tree away from the way just used
    function automatic plru_t plru_touch(input plru_t p, input way_t w);
        plru_t n;
        n = p;
        if (w < 2'd2) begin
            n[0] = 1'b1;
            n[1] = (w == 2'd0);
        end else begin
            n[0] = 1'b0;
            n[2] = (w == 2'd2);
        end
        return n;
    endfunction

    task automatic load_patterns();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        logic [7:0] port;
        addr_t      a;
        word_t      d;
        fd = $fopen("bench/l2_cache_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/l2_cache_patterns.txt from the current directory");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment and blank lines
            if (n <= 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %c %h %h", op, port, a, d);
            if (n == 4) begin
                op_q.push_back(op);
                port_q.push_back(port);
                addr_q.push_back(a);
                wdata_q.push_back(d);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            $display("pattern file holds no operations");
            stop_run();
        end
    endtask

    // wait for one port's done, the other port must stay quiet meanwhile
    task automatic wait_done(input logic want_dc);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (want_dc) begin
                check_value("ic_done", 512'(ic_done), 512'(1'b0));
                seen = dc_done;
            end else begin
                check_value("dc_done", 512'(dc_done), 512'(1'b0));
                seen = ic_done;
            end
        end
    endtask

    // predict hit or victim, check data and memory traffic, then update models
    task automatic finish_access(input string who, input addr_t a, input logic rw,
                                 input word_t d);
        logic [INDEX_BITS-1:0] set_idx;
        logic [TAG_BITS-1:0]   tag;
        logic                  hit;
        logic                  found;
        logic                  wb;
        way_t                  way;
        line_addr_t            wb_addr;
        int                    n_exp;
        set_idx = a[INDEX_BITS+1:2];
        tag     = a[ADDR_BITS-1 -: TAG_BITS];
        hit     = 1'b0;
        wb      = 1'b0;
        way     = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            // lowest invalid way first
            found = 1'b0;
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[set_idx][w]) begin
                    found = 1'b1;
                    way   = way_t'(w);
                end
            end
            if (!found) begin
                way = plru_pick(m_plru[set_idx]);
            end
            wb = m_valid[set_idx][way] && m_dirty[set_idx][way];
        end
        if (!rw) begin
            check_value({who, " rdata"}, 512'(rdata), 512'(ref_word(a)));
        end
        n_exp = hit ? 0 : (wb ? 2 : 1);
        check_value({who, " memory command count"}, 512'(log_rw.size() - log_seen),
                    512'(n_exp));
        if (wb) begin
            wb_addr = {m_tag[set_idx][way], set_idx};
            check_value({who, " writeback mem_cmd.rw"}, 512'(log_rw[log_seen]), 512'(1'b1));
            check_value({who, " writeback mem_cmd.line_addr"}, 512'(log_addr[log_seen]),
                        512'(wb_addr));
            check_value({who, " writeback mem_cmd.wdata"}, log_data[log_seen],
                        ref_line(wb_addr));
            log_seen++;
        end
        if (!hit) begin
            check_value({who, " refill mem_cmd.rw"}, 512'(log_rw[log_seen]), 512'(1'b0));
            check_value({who, " refill mem_cmd.line_addr"}, 512'(log_addr[log_seen]),
                        512'(a[ADDR_BITS-1:2]));
            log_seen++;
            m_tag[set_idx][way]   = tag;
            m_valid[set_idx][way] = 1'b1;
            m_dirty[set_idx][way] = rw;
        end else if (rw) begin
            m_dirty[set_idx][way] = 1'b1;
        end
        m_plru[set_idx] = plru_touch(m_plru[set_idx], way);
        if (rw) begin
            ref_words[a] = d;
        end
    endtask

    task automatic run_pattern(input logic [7:0] op, input logic [7:0] port, input addr_t a,
                               input word_t d);
        logic rw;
        logic use_ic;
        logic use_dc;
        rw     = (op == "W");
        use_ic = (port == "i") || (port == "b");
        use_dc = (port == "d") || (port == "b");
        @(posedge clk);
        #1;
        started = 1'b1;
        if (use_ic) begin
            ic_cmd.addr  = a;
            ic_cmd.rw    = rw;
            ic_cmd.wdata = d;
            ic_req       = 1'b1;
        end
        if (use_dc) begin
            // both ports at once: dc takes the next word and inverted data
            dc_cmd.addr  = (port == "b") ? a + 28'd1 : a;
            dc_cmd.rw    = rw;
            dc_cmd.wdata = (port == "b") ? ~d : d;
            dc_req       = 1'b1;
        end
        // ic has priority, so it finishes first
        if (use_ic) begin
            wait_done(1'b0);
            finish_access("ic", ic_cmd.addr, rw, ic_cmd.wdata);
            @(posedge clk);
            #1;
            ic_req = 1'b0;
        end
        if (use_dc) begin
            wait_done(1'b1);
            finish_access("dc", dc_cmd.addr, rw, dc_cmd.wdata);
            @(posedge clk);
            #1;
            dc_req = 1'b0;
        end
    endtask

    // memory with 1 to 4 cycles of latency per line transfer
    initial begin : memory_model
        mem_done  = 1'b0;
        mem_rdata = '0;
        rng       = 32'd98907;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                req_cmd = mem_cmd;
                log_rw.push_back(req_cmd.rw);
                log_addr.push_back(req_cmd.line_addr);
                log_data.push_back(req_cmd.wdata);
                rng = xorshift32(rng);
                lat = 1 + int'(rng % 32'd4);
                repeat (lat) @(posedge clk);
                #1;
                // request must still be held
                check_value("mem_req", 512'(mem_req), 512'(1'b1));
                if (req_cmd.rw) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem_words[{req_cmd.line_addr, word_sel_t'(w)}] =
                            req_cmd.wdata[w*128 +: 128];
                    end
                end else begin
                    mem_rdata = mem_line(req_cmd.line_addr);
                end
                mem_done = 1'b1;
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

    // quiet outputs through reset and until the first request
    always @(negedge clk) begin
        if (!started) begin
            check_value("ic_done", 512'(ic_done), 512'(1'b0));
            check_value("dc_done", 512'(dc_done), 512'(1'b0));
            check_value("mem_req", 512'(mem_req), 512'(1'b0));
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (limit > 0 && cycles >= limit) begin
                $display("timeout after %0d cycles, the DUT did not finish the patterns",
                         cycles);
                stop_run();
            end
        end
    end

    initial begin : main
        rst_n    = 1'b0;
        ic_req   = 1'b0;
        ic_cmd   = '0;
        dc_req   = 1'b0;
        dc_cmd   = '0;
        started  = 1'b0;
        limit    = 0;
        log_seen = 0;
        for (int s = 0; s < SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        load_patterns();
        // room for a double miss with writebacks on every line
        limit = op_q.size() * 40 + 100;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            run_pattern(op_q[i], port_q[i], addr_q[i], wdata_q[i]);
        end
        repeat (2) @(posedge clk);
        // no stray memory traffic after the last access
        check_value("unexpected memory commands", 512'(log_rw.size() - log_seen), 512'(0));
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: l2_cache.f
common/l2_cache_pkg.sv
rtl/l2_req_arbiter.sv
rtl/l2_tag_store.sv
rtl/l2_data_store.sv
l2_ctrl/l2_way_select.sv
l2_ctrl/l2_ctrl_fsm.sv
rtl/l2_cache_top.sv
bench/l2_cache_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := l2_cache_tb
FILELIST := l2_cache.f

SOURCES  := $(shell cat $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: bench/l2_cache_patterns.txt
# columns: op (R read, W write), port (i, d, b = both; dc takes addr+1 and inverted wdata),
# 28-bit word address in hex, 128-bit write data in hex (ignored for reads)
R i 000004C 0
R d 000004D 0
W d 000004E 0123456789abcdef0fedcba987654321
R i 000004E 0
R d 000008C 0
W i 00000CD 11112222333344445555666677778888
R d 000010C 0
R i 000014C 0
R d 000004F 0
R i 00000CD 0
W b 0000200 a5a5a5a55a5a5a5aa5a5a5a55a5a5a5a
R b 0000200 0
R b 0000304 0
W d 000001C 000000000000000000000000000000c1
W i 000005D 000000000000000000000000000000c2
W d 000009E 000000000000000000000000000000c3
W i 00000DF 000000000000000000000000000000c4
W d 000011C 000000000000000000000000000000c5
R i 000015C 0
R b 000001C 0
R d 000005D 0
R i 000009E 0
W b 0fffff8 cafef00dcafef00dcafef00dcafef00d
R b 0fffff8 0
R d 000011C 0
R i 00000DF 0
W i 000004C 00000000deadbeef00000000deadbeef
R b 000004C 0
